// ==== tp_macros.svh ====
`ifndef TP_MACROS_SVH
`define TP_MACROS_SVH

// one cache word and one DMA word, which is also one bank burst
`define TP_WORD_W 32
`define TP_DMA_W 64

// cache geometry
`define TP_BLOCK_WORDS 8
`define TP_SETS 16
`define TP_WAYS 2
`define TP_SET_W 4
`define TP_WAY_W 1

// half the block sits in each bank, split into DMA-wide bursts
`define TP_BURSTS ((`TP_BLOCK_WORDS / 2) * `TP_WORD_W / `TP_DMA_W)
`define TP_BURST_W 1
`define TP_BANK_ADDR_W 5
`define TP_MASK_W 8
`define TP_BLOCK_BYTES (`TP_BLOCK_WORDS * `TP_WORD_W / 8)

`endif

// ==== tp_pkg.sv ====
`include "tp_macros.svh"

package tp_pkg;

  // only one operation runs at a time
  typedef enum logic [1:0] {
    TP_IDLE   = 2'd0,
    TP_EVICT  = 2'd1,
    TP_REFILL = 2'd2
  } tp_mode_e;

  // command as captured from the miss handler
  typedef struct packed {
    logic [`TP_WAY_W-1:0]       way;
    logic [`TP_SET_W-1:0]       index;
    logic                       track_miss;
    // one bit per block word, set where the word is already valid
    logic [`TP_BLOCK_WORDS-1:0] track;
    // pending store bytes, these always take the refill data
    logic [`TP_BLOCK_BYTES-1:0] byte_mask;
  } tp_cmd_s;

  // a refill beat is two DMA words, or four block words in order
  typedef union packed {
    logic [1:0][`TP_DMA_W-1:0]  dma;
    logic [3:0][`TP_WORD_W-1:0] word;
  } tp_beat_u;

  // one data-memory bank access
  typedef struct packed {
    logic                                     valid;
    logic                                     write;
    logic [`TP_BANK_ADDR_W-1:0]               addr;
    logic [`TP_DMA_W-1:0]                     data;
    logic [`TP_WAYS-1:0][`TP_MASK_W-1:0]      mask;
  } tp_bank_req_s;

endpackage

// ==== tp_cmd_decode.sv ====
`timescale 1ns/100ps

module tp_cmd_decode (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               evict_we_i,
  input  logic               refill_we_i,
  input  tp_pkg::tp_cmd_s    cmd_i,
  input  logic               even_done_i,
  input  logic               odd_done_i,
  input  logic               port_idle_i,
  output tp_pkg::tp_mode_e   mode_o,
  output tp_pkg::tp_cmd_s    cmd_o,
  output logic               evict_busy_o,
  output logic               refill_busy_o,
  output logic               evict_done_o,
  output logic               refill_done_o
);

  tp_pkg::tp_mode_e mode_r;
  tp_pkg::tp_cmd_s  cmd_r;
  logic             lanes_done;
  logic             accept;

  assign lanes_done = even_done_i & odd_done_i;
  // strobes are only taken while idle, anything else is dropped
  assign accept = (mode_r == tp_pkg::TP_IDLE) & (evict_we_i | refill_we_i);

  // eviction also waits until the last DMA word has left the port
  assign evict_done_o  = (mode_r == tp_pkg::TP_EVICT) & lanes_done & port_idle_i;
  assign refill_done_o = (mode_r == tp_pkg::TP_REFILL) & lanes_done;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mode_r <= tp_pkg::TP_IDLE;
    end else begin
      case (mode_r)
        tp_pkg::TP_IDLE: begin
          if (evict_we_i) begin
            mode_r <= tp_pkg::TP_EVICT;
          end else if (refill_we_i) begin
            mode_r <= tp_pkg::TP_REFILL;
          end
        end
        tp_pkg::TP_EVICT: begin
          if (evict_done_o) begin
            mode_r <= tp_pkg::TP_IDLE;
          end
        end
        tp_pkg::TP_REFILL: begin
          if (refill_done_o) begin
            mode_r <= tp_pkg::TP_IDLE;
          end
        end
        default: mode_r <= tp_pkg::TP_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      cmd_r <= cmd_i;
    end
  end

  assign mode_o        = mode_r;
  assign cmd_o         = cmd_r;
  assign evict_busy_o  = (mode_r == tp_pkg::TP_EVICT);
  assign refill_busy_o = (mode_r == tp_pkg::TP_REFILL);

endmodule

// ==== tp_bank_lane.sv ====
`timescale 1ns/100ps
`include "tp_macros.svh"

module tp_bank_lane #(
  parameter int bank_parity_p = 0
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  tp_pkg::tp_mode_e                     mode_i,
  input  tp_pkg::tp_cmd_s                      cmd_i,
  input  logic                                 grant_i,
  input  logic [`TP_WAYS-1:0][`TP_DMA_W-1:0]   rdata_i,
  input  logic [`TP_DMA_W-1:0]                 fill_data_i,
  input  logic                                 fill_v_i,
  input  logic                                 q_yumi_i,
  output logic                                 fill_ready_o,
  output logic                                 q_v_o,
  output logic [`TP_DMA_W-1:0]                 q_data_o,
  output tp_pkg::tp_bank_req_s                 bank_o,
  output logic                                 lane_done_o
);

  localparam int cnt_w_lp = `TP_BURST_W + 1;
  localparam logic [cnt_w_lp-1:0] bursts_lp = cnt_w_lp'(`TP_BURSTS);
  localparam int halves_lp = `TP_DMA_W / `TP_WORD_W;
  localparam int word_bytes_lp = `TP_WORD_W / 8;

  logic                         evicting;
  logic                         refilling;
  logic [cnt_w_lp-1:0]          cnt_r;
  logic                         rd_pend_r;
  logic                         rd_go;
  logic                         wr_go;
  logic                         q_room;
  logic                         enq;
  logic                         deq;
  logic [`TP_DMA_W-1:0]         enq_data;
  logic [1:0][`TP_DMA_W-1:0]    q_mem;
  logic                         q_wptr_r;
  logic                         q_rptr_r;
  logic [1:0]                   q_cnt_r;
  logic [`TP_BURST_W-1:0]       burst;
  logic [2:0]                   word_idx;
  logic [`TP_MASK_W-1:0]        burst_mask;

  assign evicting  = (mode_i == tp_pkg::TP_EVICT);
  assign refilling = (mode_i == tp_pkg::TP_REFILL);
  assign burst     = cnt_r[`TP_BURST_W-1:0];

  // a read reserves its queue slot, since data comes back a cycle later
  assign q_room = (q_cnt_r == 2'd0) | ((q_cnt_r == 2'd1) & ~rd_pend_r);
  assign rd_go  = evicting & grant_i & (cnt_r < bursts_lp) & q_room;
  assign wr_go  = refilling & grant_i & q_v_o & (cnt_r < bursts_lp);

  // refill words in flight never exceed what is still to be written
  assign fill_ready_o = refilling & (q_cnt_r != 2'd2)
                      & (({1'b0, cnt_r} + {1'b0, q_cnt_r}) < {1'b0, bursts_lp});

  assign enq      = (evicting & rd_pend_r) | (fill_v_i & fill_ready_o);
  assign enq_data = evicting ? rdata_i[cmd_i.way] : fill_data_i;
  assign deq      = q_yumi_i | wr_go;

  always_ff @(posedge clk_i) begin
    if (reset_i || mode_i == tp_pkg::TP_IDLE) begin
      cnt_r <= '0;
    end else if (rd_go || wr_go) begin
      cnt_r <= cnt_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_pend_r <= 1'b0;
    end else begin
      rd_pend_r <= rd_go;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      q_wptr_r <= 1'b0;
      q_rptr_r <= 1'b0;
      q_cnt_r  <= 2'd0;
    end else begin
      if (enq) begin
        q_wptr_r <= ~q_wptr_r;
      end
      if (deq) begin
        q_rptr_r <= ~q_rptr_r;
      end
      case ({enq, deq})
        2'b10:   q_cnt_r <= q_cnt_r + 2'd1;
        2'b01:   q_cnt_r <= q_cnt_r - 2'd1;
        default: q_cnt_r <= q_cnt_r;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      q_mem[q_wptr_r] <= enq_data;
    end
  end

  assign q_v_o    = (q_cnt_r != 2'd0);
  assign q_data_o = q_mem[q_rptr_r];

  // burst b of this bank holds block words 4b+p and 4b+2+p
  always_comb begin
    burst_mask = '0;
    word_idx   = '0;
    for (int h = 0; h < halves_lp; h++) begin
      for (int k = 0; k < word_bytes_lp; k++) begin
        word_idx = {burst, h[0], 1'(bank_parity_p)};
        burst_mask[h*word_bytes_lp+k] = ~cmd_i.track_miss | ~cmd_i.track[word_idx]
                                      | cmd_i.byte_mask[{word_idx, k[1:0]}];
      end
    end
  end

  always_comb begin
    bank_o.valid = rd_go | wr_go;
    bank_o.write = refilling;
    bank_o.addr  = {cmd_i.index, burst};
    bank_o.data  = q_data_o;
    for (int i = 0; i < `TP_WAYS; i++) begin
      bank_o.mask[i] = (refilling && cmd_i.way == i) ? burst_mask : '0;
    end
  end

  assign lane_done_o = (evicting & (cnt_r == bursts_lp) & ~rd_pend_r)
                     | (refilling & (cnt_r == bursts_lp));

endmodule

// ==== tp_dma_port.sv ====
`timescale 1ns/100ps
`include "tp_macros.svh"

module tp_dma_port (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  tp_pkg::tp_mode_e       mode_i,
  input  logic                   even_q_v_i,
  input  logic                   odd_q_v_i,
  input  logic [`TP_DMA_W-1:0]   even_q_data_i,
  input  logic [`TP_DMA_W-1:0]   odd_q_data_i,
  input  logic                   even_fill_ready_i,
  input  logic                   odd_fill_ready_i,
  input  tp_pkg::tp_beat_u       dma_refill_data_i,
  input  logic                   dma_refill_v_i,
  input  logic                   dma_evict_yumi_i,
  output logic                   q_yumi_o,
  output logic                   fill_v_o,
  output logic [`TP_DMA_W-1:0]   even_fill_data_o,
  output logic [`TP_DMA_W-1:0]   odd_fill_data_o,
  output logic                   dma_refill_ready_o,
  output logic                   dma_evict_v_o,
  output logic [`TP_DMA_W-1:0]   dma_evict_data_o,
  output logic                   idle_o
);

  localparam int half_w_lp = `TP_WORD_W;

  logic [1:0][`TP_DMA_W-1:0] ser_r;
  logic [1:0]                ser_cnt_r;
  logic                      pop;

  // both bank heads leave together, and only into an empty serializer
  assign pop = (mode_i == tp_pkg::TP_EVICT) & even_q_v_i & odd_q_v_i & (ser_cnt_r == 2'd0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ser_cnt_r <= 2'd0;
    end else if (pop) begin
      ser_cnt_r <= 2'd2;
    end else if (dma_evict_yumi_i && ser_cnt_r != 2'd0) begin
      ser_cnt_r <= ser_cnt_r - 2'd1;
    end
  end

  // the low halves of a burst pair make the earlier DMA word
  always_ff @(posedge clk_i) begin
    if (pop) begin
      ser_r[0] <= {odd_q_data_i[half_w_lp-1:0], even_q_data_i[half_w_lp-1:0]};
      ser_r[1] <= {odd_q_data_i[`TP_DMA_W-1:half_w_lp], even_q_data_i[`TP_DMA_W-1:half_w_lp]};
    end else if (dma_evict_yumi_i) begin
      ser_r[0] <= ser_r[1];
    end
  end

  assign q_yumi_o         = pop;
  assign dma_evict_v_o    = (ser_cnt_r != 2'd0);
  assign dma_evict_data_o = ser_r[0];
  assign idle_o           = (ser_cnt_r == 2'd0) & ~even_q_v_i & ~odd_q_v_i;

  // even-numbered block words go to the even bank, odd-numbered ones to the odd bank
  assign even_fill_data_o = {dma_refill_data_i.word[2], dma_refill_data_i.word[0]};
  assign odd_fill_data_o  = {dma_refill_data_i.word[3], dma_refill_data_i.word[1]};

  assign dma_refill_ready_o = (mode_i == tp_pkg::TP_REFILL) & even_fill_ready_i & odd_fill_ready_i;
  assign fill_v_o           = dma_refill_v_i & dma_refill_ready_o;

endmodule

// ==== evict_fill_transmitter.sv ====
`timescale 1ns/100ps
`include "tp_macros.svh"

module evict_fill_transmitter (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                evict_we_i,
  input  logic                                refill_we_i,
  input  tp_pkg::tp_cmd_s                     cmd_i,
  input  logic                                even_grant_i,
  input  logic                                odd_grant_i,
  input  logic [`TP_WAYS-1:0][`TP_DMA_W-1:0]  even_rdata_i,
  input  logic [`TP_WAYS-1:0][`TP_DMA_W-1:0]  odd_rdata_i,
  input  tp_pkg::tp_beat_u                    dma_refill_data_i,
  input  logic                                dma_refill_v_i,
  input  logic                                dma_evict_yumi_i,
  output tp_pkg::tp_bank_req_s                even_bank_o,
  output tp_pkg::tp_bank_req_s                odd_bank_o,
  output logic                                dma_refill_ready_o,
  output logic                                dma_evict_v_o,
  output logic [`TP_DMA_W-1:0]                dma_evict_data_o,
  output logic                                evict_busy_o,
  output logic                                refill_busy_o,
  output logic                                evict_done_o,
  output logic                                refill_done_o
);

  tp_pkg::tp_mode_e     mode;
  tp_pkg::tp_cmd_s      cmd;
  logic                 even_done, odd_done, port_idle;
  logic                 even_q_v, odd_q_v, q_yumi;
  logic [`TP_DMA_W-1:0] even_q_data, odd_q_data;
  logic                 even_fill_ready, odd_fill_ready, fill_v;
  logic [`TP_DMA_W-1:0] even_fill_data, odd_fill_data;

  tp_cmd_decode decode0 (
    .clk_i, .reset_i, .evict_we_i, .refill_we_i, .cmd_i,
    .even_done_i(even_done), .odd_done_i(odd_done), .port_idle_i(port_idle),
    .mode_o(mode), .cmd_o(cmd),
    .evict_busy_o, .refill_busy_o, .evict_done_o, .refill_done_o
  );

  tp_bank_lane #(.bank_parity_p(0)) even_lane (
    .clk_i, .reset_i, .mode_i(mode), .cmd_i(cmd), .grant_i(even_grant_i),
    .rdata_i(even_rdata_i), .fill_data_i(even_fill_data), .fill_v_i(fill_v),
    .q_yumi_i(q_yumi), .fill_ready_o(even_fill_ready), .q_v_o(even_q_v),
    .q_data_o(even_q_data), .bank_o(even_bank_o), .lane_done_o(even_done)
  );

  tp_bank_lane #(.bank_parity_p(1)) odd_lane (
    .clk_i, .reset_i, .mode_i(mode), .cmd_i(cmd), .grant_i(odd_grant_i),
    .rdata_i(odd_rdata_i), .fill_data_i(odd_fill_data), .fill_v_i(fill_v),
    .q_yumi_i(q_yumi), .fill_ready_o(odd_fill_ready), .q_v_o(odd_q_v),
    .q_data_o(odd_q_data), .bank_o(odd_bank_o), .lane_done_o(odd_done)
  );

  tp_dma_port port0 (
    .clk_i, .reset_i, .mode_i(mode),
    .even_q_v_i(even_q_v), .odd_q_v_i(odd_q_v),
    .even_q_data_i(even_q_data), .odd_q_data_i(odd_q_data),
    .even_fill_ready_i(even_fill_ready), .odd_fill_ready_i(odd_fill_ready),
    .dma_refill_data_i, .dma_refill_v_i, .dma_evict_yumi_i,
    .q_yumi_o(q_yumi), .fill_v_o(fill_v),
    .even_fill_data_o(even_fill_data), .odd_fill_data_o(odd_fill_data),
    .dma_refill_ready_o, .dma_evict_v_o, .dma_evict_data_o, .idle_o(port_idle)
  );

endmodule

// ==== tb_transmitter.sv ====
`timescale 1ns/100ps
`include "tp_macros.svh"

module tb_transmitter;

  localparam int timeout_lp = 400;
  localparam int addrs_lp = `TP_SETS * `TP_BURSTS;

  logic                                 clk_i, reset_i, evict_we_i, refill_we_i;
  tp_pkg::tp_cmd_s                      cmd_i;
  logic                                 even_grant_i, odd_grant_i;
  logic [`TP_WAYS-1:0][`TP_DMA_W-1:0]   even_rdata_i, odd_rdata_i;
  tp_pkg::tp_beat_u                     dma_refill_data_i;
  logic                                 dma_refill_v_i, dma_evict_yumi_i;
  tp_pkg::tp_bank_req_s                 even_bank_o, odd_bank_o;
  logic                                 dma_refill_ready_o, dma_evict_v_o;
  logic [`TP_DMA_W-1:0]                 dma_evict_data_o;
  logic                                 evict_busy_o, refill_busy_o, evict_done_o, refill_done_o;

  // bank model and its expected image, indexed by bank, way and bank address
  logic [`TP_DMA_W-1:0]  mem [2][`TP_WAYS][addrs_lp];
  logic [`TP_DMA_W-1:0]  exp_mem [2][`TP_WAYS][addrs_lp];
  tp_pkg::tp_bank_req_s  req_seen [2];
  logic [`TP_WORD_W-1:0] vw [`TP_BLOCK_WORDS];
  logic [`TP_DMA_W-1:0]  evict_words [$];
  logic [16:0]           lfsr_r = 17'd75217;
  logic                  sparse;
  logic                  aborted;
  int evict_dones, refill_dones, beats_taken, words_at_done;
  int test_errs, tests_run, tests_failed;

  evict_fill_transmitter dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // x^17 + x^14 + 1
  function automatic logic rand_bit();
    lfsr_r = {lfsr_r[15:0], lfsr_r[16] ^ lfsr_r[13]};
    return lfsr_r[0];
  endfunction

  function automatic logic [`TP_DMA_W-1:0] old_data(input int b, input int w, input int a);
    return {8'(a), 8'(w), 8'(b), 8'h5a, ~8'(a), 8'(a * 13 + w), 8'h3c ^ 8'(b), 8'(a ^ 7)};
  endfunction

  // everything is sampled mid-cycle, where DUT outputs have settled
  always @(negedge clk_i) begin
    req_seen[0] = even_bank_o;
    req_seen[1] = odd_bank_o;
    if (evict_done_o) begin
      evict_dones++;
      words_at_done = evict_words.size();
    end
    if (refill_done_o) refill_dones++;
    if (dma_evict_v_o && dma_evict_yumi_i) evict_words.push_back(dma_evict_data_o);
    if (dma_refill_v_i && dma_refill_ready_o) beats_taken++;
  end

  task automatic report(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    test_errs++;
  endtask

  // a request seen in the last cycle writes now, or returns read data for this cycle
  task automatic serve_bank(input int b);
    tp_pkg::tp_bank_req_s r;
    logic [`TP_WAYS-1:0][`TP_DMA_W-1:0] rd;
    r = req_seen[b];
    if (r.valid === 1'b1) begin
      for (int w = 0; w < `TP_WAYS; w++) begin
        rd[w] = mem[b][w][r.addr];
        for (int j = 0; j < `TP_MASK_W; j++) begin
          if (r.write && r.mask[w][j]) mem[b][w][r.addr][j*8 +: 8] = r.data[j*8 +: 8];
        end
      end
      if (!r.write && b == 0) even_rdata_i = rd;
      if (!r.write && b == 1) odd_rdata_i = rd;
    end
  endtask

  task automatic step();
    @(posedge clk_i);
    #1;
    serve_bank(0);
    serve_bank(1);
    even_grant_i     = sparse ? (rand_bit() & rand_bit()) : 1'b1;
    odd_grant_i      = sparse ? (rand_bit() & rand_bit()) : 1'b1;
    // yumi only ever answers a valid DMA word
    dma_evict_yumi_i = dma_evict_v_o & (sparse ? (rand_bit() & rand_bit()) : 1'b1);
  endtask

  task automatic check_quiet(input string when);
    @(negedge clk_i);
    if (evict_busy_o !== 1'b0 || refill_busy_o !== 1'b0 || even_bank_o.valid !== 1'b0
        || odd_bank_o.valid !== 1'b0 || dma_evict_v_o !== 1'b0
        || dma_refill_ready_o !== 1'b0 || evict_done_o !== 1'b0 || refill_done_o !== 1'b0)
      report({"an output is not low ", when});
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errs != 0) tests_failed++;
    $display("test %0d %s: %s", tests_run, name, (test_errs == 0) ? "ok" : "mismatch");
  endtask

  // block word w sits in bank w%2, burst w/4, half (w/2)%2
  task automatic place_block(input tp_pkg::tp_cmd_s c, input logic merge);
    int a;
    int lo;
    for (int w = 0; w < `TP_BLOCK_WORDS; w++) begin
      a  = c.index * `TP_BURSTS + w / 4;
      lo = ((w / 2) % 2) * `TP_WORD_W;
      for (int k = 0; k < 4; k++) begin
        if (!merge || !c.track_miss || !c.track[w] || c.byte_mask[w*4+k])
          exp_mem[w%2][c.way][a][lo + k*8 +: 8] = vw[w][k*8 +: 8];
      end
    end
  endtask

  task automatic run_test(input logic evict, input tp_pkg::tp_cmd_s c);
    int t;
    for (int b = 0; b < 2; b++)
      for (int w = 0; w < `TP_WAYS; w++)
        for (int a = 0; a < addrs_lp; a++)
          exp_mem[b][w][a] = old_data(b, w, a);
    if (evict) place_block(c, 1'b0);
    mem = exp_mem;
    if (!evict) place_block(c, 1'b1);
    evict_dones = 0;
    refill_dones = 0;
    beats_taken = 0;
    words_at_done = -1;
    evict_words.delete();
    cmd_i = c;
    evict_we_i = evict;
    refill_we_i = !evict;
    step();
    evict_we_i = 1'b0;
    refill_we_i = 1'b0;
    if ((evict ? evict_busy_o : refill_busy_o) !== 1'b1) report("busy did not rise");
    // a strobe while busy must not change the running command
    cmd_i = ~c;
    evict_we_i = 1'b1;
    refill_we_i = 1'b1;
    step();
    evict_we_i = 1'b0;
    refill_we_i = 1'b0;
    t = 0;
    while ((evict ? evict_dones : refill_dones) == 0) begin
      dma_refill_v_i = 1'b0;
      if (!evict && beats_taken < 2) begin
        dma_refill_v_i = sparse ? rand_bit() : 1'b1;
        dma_refill_data_i.dma[0] = {vw[4*beats_taken+1], vw[4*beats_taken]};
        dma_refill_data_i.dma[1] = {vw[4*beats_taken+3], vw[4*beats_taken+2]};
      end
      step();
      t++;
      if (t > timeout_lp) begin
        $display("timeout: no done pulse after %0d cycles", timeout_lp);
        test_errs++;
        aborted = 1'b1;
        break;
      end
    end
    dma_refill_v_i = 1'b0;
    t = 0;
    while (!aborted && (evict_busy_o || refill_busy_o)) begin
      step();
      t++;
      if (t > 10) begin
        $display("timeout: busy stayed high after the done pulse");
        test_errs++;
        aborted = 1'b1;
      end
    end
    for (int i = 0; i < 4; i++) step();
    if (evict_dones + refill_dones != 1)
      report($sformatf("%0d done pulses, expected one", evict_dones + refill_dones));
    if (evict) begin
      if (evict_words.size() != 4 || words_at_done != 4)
        report($sformatf("%0d DMA words, %0d before done", evict_words.size(), words_at_done));
      for (int k = 0; k < 4 && k < evict_words.size(); k++) begin
        if (evict_words[k] !== {vw[2*k+1], vw[2*k]})
          report($sformatf("DMA word %0d is %h, expected %h", k, evict_words[k],
                           {vw[2*k+1], vw[2*k]}));
      end
    end else begin
      for (int b = 0; b < 2; b++)
        for (int w = 0; w < `TP_WAYS; w++)
          for (int a = 0; a < addrs_lp; a++)
            if (mem[b][w][a] !== exp_mem[b][w][a])
              report($sformatf("bank %0d way %0d addr %0d holds %h, expected %h",
                               b, w, a, mem[b][w][a], exp_mem[b][w][a]));
    end
  endtask

  task automatic run_pass(input logic sp);
    int fd;
    string line;
    logic [3:0] op, way, idx, tm;
    logic [7:0] trk;
    logic [31:0] bm;
    tp_pkg::tp_cmd_s c;
    sparse = sp;
    fd = $fopen("tb_transmitter_vectors.txt", "r");
    if (fd == 0) begin
      $display("the vector file could not be opened");
      tests_failed++;
      return;
    end
    while (!aborted && $fgets(line, fd) > 0) begin
      if (line.len() < 2 || line[0] == "#") continue;
      test_errs = 0;
      if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h", op, way, idx, tm, trk, bm,
                  vw[0], vw[1], vw[2], vw[3], vw[4], vw[5], vw[6], vw[7]) != 14) begin
        $display("a vector line is malformed: %s", line);
        test_errs++;
      end else begin
        c.way        = way[0];
        c.index      = idx;
        c.track_miss = tm[0];
        c.track      = trk;
        c.byte_mask  = bm;
        run_test(op == 4'd1, c);
      end
      finish_test($sformatf("%s %s way %0d set %0d%s", sp ? "sparse" : "dense",
                            (op == 4'd1) ? "evict" : "refill", way, idx,
                            tm[0] ? " track miss" : ""));
    end
    $fclose(fd);
  endtask

  initial begin
    reset_i = 1'b1;
    evict_we_i = 1'b0;
    refill_we_i = 1'b0;
    cmd_i = '0;
    even_grant_i = 1'b0;
    odd_grant_i = 1'b0;
    even_rdata_i = '0;
    odd_rdata_i = '0;
    dma_refill_data_i = '0;
    dma_refill_v_i = 1'b0;
    dma_evict_yumi_i = 1'b0;
    req_seen[0] = '0;
    req_seen[1] = '0;
    sparse = 1'b0;
    aborted = 1'b0;
    tests_run = 0;
    tests_failed = 0;
    test_errs = 0;
    for (int i = 0; i < 5; i++) begin
      step();
      check_quiet("during reset");
    end
    reset_i = 1'b0;
    step();
    check_quiet("after reset");
    finish_test("reset state");
    run_pass(1'b0);
    run_pass(1'b1);
    $display("%0d tests run, %0d passed, %0d failed", tests_run, tests_run - tests_failed,
             tests_failed);
    if (tests_failed == 0 && tests_run > 1 && !aborted)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// ==== tb_transmitter_vectors.txt ====
# op (1 evict, 2 refill)  way  set  track_miss  track[7:0]  byte_mask[31:0]
# then block words 0 to 7, every column in hex
2 0 3 0 00 00000000 10000000 10000001 10000002 10000003 10000004 10000005 10000006 10000007
2 1 3 0 00 00000000 2a2b2c2d 3a3b3c3d 4a4b4c4d 5a5b5c5d 6a6b6c6d 7a7b7c7d 8a8b8c8d 9a9b9c9d
1 0 5 0 00 00000000 a0a1a2a3 b0b1b2b3 c0c1c2c3 d0d1d2d3 e0e1e2e3 f0f1f2f3 01234567 89abcdef
1 1 f 0 00 00000000 deadbeef feedface 0badf00d cafebabe 13579bdf 2468ace0 fedcba98 76543210
2 0 7 1 a5 00000000 11111111 22222222 33333333 44444444 55555555 66666666 77777777 88888888
2 1 c 1 3c 0f00f0f1 99999999 aaaaaaaa bbbbbbbb cccccccc dddddddd eeeeeeee ffffffff 12121212
2 0 0 1 ff 80000001 31415926 53589793 23846264 33832795 02884197 16939937 51058209 74944592
1 0 0 0 00 00000000 00000001 00000002 00000004 00000008 00000010 00000020 00000040 00000080
2 1 9 1 00 ffffffff 5555aaaa aaaa5555 0f0f0f0f f0f0f0f0 00ff00ff ff00ff00 12345678 9abcdef0

// ==== build.f ====
+incdir+.
tp_pkg.sv
tp_cmd_decode.sv
tp_bank_lane.sv
tp_dma_port.sv
evict_fill_transmitter.sv
tb_transmitter.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f build.f --top-module tb_transmitter -o tb_sim
./obj_dir/tb_sim > sim.log
cat sim.log
if grep -q "tests failed" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation finished without failures"
